// File: i2cSensorPkg.sv
package i2cSensorPkg;

    // one byte on the bus
    typedef logic [7:0] byteT;

    // temperature result, high byte first
    typedef logic [15:0] wordT;

    // conversion wait and sample interval counts
    typedef logic [31:0] timerT;

    // commands from the sequencer to the byte master
    typedef struct packed {
        logic startProcess;
        logic receiveSend_n;
        byteT readCount;
        logic fifoWrite;
        logic fifoReadNext;
        byteT data;
    } i2cCtrlT;

    // status from the byte master back to the sequencer
    typedef struct packed {
        logic busy;
        logic error;
        byteT data;
    } i2cStatT;

endpackage

// File: i2cByteFifo.sv
`timescale 1ns/1ps

module i2cByteFifo
#(
    parameter int FifoDepth = 4
)
(
    input  logic               Clk_i,
    input  logic               rst_i,
    input  logic               push_i,
    input  i2cSensorPkg::byteT pushData_i,
    input  logic               pop_i,
    output i2cSensorPkg::byteT head_o,
    output logic               empty_o,
    output logic               full_o
);

    localparam int PtrW = $clog2(FifoDepth);
    localparam int CntW = $clog2(FifoDepth + 1);

    i2cSensorPkg::byteT mem [FifoDepth];
    logic [PtrW-1:0]    rdPtr;
    logic [PtrW-1:0]    wrPtr;
    logic [CntW-1:0]    count;

    always_ff @(posedge Clk_i)
    begin
        if (push_i)
            mem[wrPtr] <= pushData_i;
    end

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            // pointers wrap explicitly so any depth works
            if (push_i)
                wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop_i)
                rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_o  = mem[rdPtr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CntW'(FifoDepth));

    noOverUnderflow: assert property (@(posedge Clk_i) disable iff (rst_i)
        !(push_i && full_o) && !(pop_i && empty_o))
        else $error("byte fifo overflow or underflow");

endmodule

// File: i2cMaster.sv
`timescale 1ns/1ps

module i2cMaster
#(
    parameter int ClkDiv    = 4,
    parameter int FifoDepth = 4
)
(
    input  logic                  Clk_i,
    input  logic                  rst_i,
    input  i2cSensorPkg::i2cCtrlT I2cCtrl_i,
    output i2cSensorPkg::i2cStatT I2cStat_o,
    input  logic                  scl_i,
    input  logic                  sda_i,
    output logic                  sclDriveLow_o,
    output logic                  sdaDriveLow_o
);

    localparam int DivW = $clog2(ClkDiv);

    typedef enum logic [2:0] {
        stIdle,
        stStart,
        stBit,
        stAck,
        stStop,
        stDrain
    } stateT;

    stateT              state;
    logic [1:0]         phase;
    logic [DivW-1:0]    divCnt;
    logic [2:0]         bitCnt;
    logic               engineRun;
    logic               tick;
    logic               lastTick;
    logic               phaseStep;
    logic               readMode;
    logic               rxActive;
    logic               nackSeen;
    i2cSensorPkg::byteT readLeft;
    i2cSensorPkg::byteT shiftReg;
    logic               loadNext;
    logic               masterPush;
    logic               masterPop;
    logic               fifoPush;
    i2cSensorPkg::byteT fifoPushData;
    logic               fifoPop;
    i2cSensorPkg::byteT fifoHead;
    logic               fifoEmpty;
    logic               fifoFull;

    // quarter SCL period divider, runs only while the bit engine is active
    assign engineRun = (state == stStart) || (state == stBit) ||
                       (state == stAck) || (state == stStop);
    assign tick      = engineRun && (divCnt == DivW'(ClkDiv - 1));
    assign lastTick  = tick && (phase == 2'd3);

    always_ff @(posedge Clk_i)
    begin
        if (rst_i || !engineRun || tick)
            divCnt <= '0;
        else
            divCnt <= divCnt + 1'b1;
    end

    // start waits in its first quarter until both lines are released
    assign phaseStep = tick && !((state == stStart) && (phase == 2'd0) && !(scl_i && sda_i));

    assign loadNext   = (state == stAck) && lastTick && !rxActive && !nackSeen &&
                        !readMode && !fifoEmpty;
    assign masterPush = (state == stBit) && lastTick && rxActive && (bitCnt == 3'd0);
    assign masterPop  = ((state == stIdle) && I2cCtrl_i.startProcess) || loadNext ||
                        ((state == stDrain) && !fifoEmpty);

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
        begin
            state    <= stIdle;
            phase    <= '0;
            bitCnt   <= '0;
            readMode <= 1'b0;
            rxActive <= 1'b0;
            nackSeen <= 1'b0;
            readLeft <= '0;
        end
        else
        begin
            if (phaseStep)
                phase <= phase + 2'd1;
            case (state)
                stIdle:
                begin
                    if (I2cCtrl_i.startProcess)
                    begin
                        state    <= stStart;
                        readMode <= I2cCtrl_i.receiveSend_n;
                        readLeft <= I2cCtrl_i.readCount;
                        rxActive <= 1'b0;
                        nackSeen <= 1'b0;
                    end
                end
                stStart:
                begin
                    if (lastTick)
                    begin
                        state  <= stBit;
                        bitCnt <= 3'd7;
                    end
                end
                stBit:
                begin
                    if (lastTick)
                    begin
                        if (bitCnt == 3'd0)
                        begin
                            state <= stAck;
                            if (rxActive)
                                readLeft <= readLeft - 1'b1;
                        end
                        else
                        begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                stAck:
                begin
                    // slave acknowledge sampled while SCL is high
                    if (tick && (phase == 2'd2) && !rxActive)
                        nackSeen <= sda_i;
                    if (lastTick)
                    begin
                        bitCnt <= 3'd7;
                        if (rxActive)
                            state <= (readLeft == '0) ? stStop : stBit;
                        else if (nackSeen)
                            state <= stStop;
                        else if (readMode)
                        begin
                            // address accepted, switch to receiving
                            rxActive <= 1'b1;
                            state    <= stBit;
                        end
                        else if (fifoEmpty)
                            state <= stStop;
                        else
                            state <= stBit;
                    end
                end
                stStop:
                begin
                    if (lastTick)
                        state <= nackSeen ? stDrain : stIdle;
                end
                stDrain:
                begin
                    // throw away bytes queued behind the refused one
                    if (fifoEmpty)
                        state <= stIdle;
                end
                default:
                begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // tx shifts out after the low quarter, rx samples in the second high quarter
    always_ff @(posedge Clk_i)
    begin
        if (masterPop)
            shiftReg <= fifoHead;
        else if ((state == stBit) && tick && rxActive && (phase == 2'd2))
            shiftReg <= {shiftReg[6:0], sda_i};
        else if ((state == stBit) && lastTick && !rxActive)
            shiftReg <= {shiftReg[6:0], 1'b0};
    end

    always_comb
    begin
        sclDriveLow_o = 1'b0;
        sdaDriveLow_o = 1'b0;
        case (state)
            stStart:
            begin
                sclDriveLow_o = (phase == 2'd3);
                sdaDriveLow_o = (phase != 2'd0);
            end
            stBit:
            begin
                sclDriveLow_o = (phase == 2'd0) || (phase == 2'd3);
                sdaDriveLow_o = !rxActive && !shiftReg[7];
            end
            stAck:
            begin
                // master ACKs every received byte but the last
                sclDriveLow_o = (phase == 2'd0) || (phase == 2'd3);
                sdaDriveLow_o = rxActive && (readLeft != '0);
            end
            stStop:
            begin
                sclDriveLow_o = (phase == 2'd0);
                sdaDriveLow_o = (phase < 2'd2);
            end
            default:
            begin
                sclDriveLow_o = 1'b0;
                sdaDriveLow_o = 1'b0;
            end
        endcase
    end

    // sequencer owns the FIFO input while idle, received bytes while busy
    assign fifoPush     = (state == stIdle) ? I2cCtrl_i.fifoWrite : masterPush;
    assign fifoPushData = (state == stIdle) ? I2cCtrl_i.data : shiftReg;
    assign fifoPop      = masterPop || I2cCtrl_i.fifoReadNext;

    i2cByteFifo
    #(
        .FifoDepth (FifoDepth)
    )
    fifoI
    (
        .Clk_i      (Clk_i),
        .rst_i      (rst_i),
        .push_i     (fifoPush),
        .pushData_i (fifoPushData),
        .pop_i      (fifoPop),
        .head_o     (fifoHead),
        .empty_o    (fifoEmpty),
        .full_o     (fifoFull)
    );

    assign I2cStat_o.busy  = (state != stIdle);
    assign I2cStat_o.error = (state == stDrain) && fifoEmpty;
    assign I2cStat_o.data  = fifoHead;

    noStartWhileBusy: assert property (@(posedge Clk_i) disable iff (rst_i)
        I2cCtrl_i.startProcess |-> !I2cStat_o.busy)
        else $error("transfer started while the master is busy");

    rxNeverFull: assert property (@(posedge Clk_i) disable iff (rst_i)
        masterPush |-> !fifoFull)
        else $error("received byte dropped on a full fifo");

endmodule

// File: adt7410Fsm.sv
`timescale 1ns/1ps

module adt7410Fsm
(
    input  logic                  Clk_i,
    input  logic                  rst_i,
    input  logic                  Start_i,
    input  i2cSensorPkg::timerT   WaitPreset_i,
    input  i2cSensorPkg::i2cStatT I2cStat_i,
    output i2cSensorPkg::i2cCtrlT I2cCtrl_o,
    output logic                  Done_o,
    output logic                  Error_o,
    output logic                  Idle_o,
    output i2cSensorPkg::wordT    Result_o
);

    // address 0x48 shifted left, R/W in bit 0
    localparam i2cSensorPkg::byteT DevWrite   = 8'h90;
    localparam i2cSensorPkg::byteT DevRead    = 8'h91;
    localparam i2cSensorPkg::byteT CfgReg     = 8'h03;
    localparam i2cSensorPkg::byteT CfgOneShot = 8'h20;
    localparam i2cSensorPkg::byteT TempReg    = 8'h00;
    localparam i2cSensorPkg::byteT ReadBytes  = 8'h02;

    typedef enum logic [3:0] {
        stIdle,
        stWriteReq1,
        stWriteReq2,
        stStartReq,
        stWaitReq,
        stWait,
        stWriteAddr1,
        stStartAddr,
        stWaitAddr,
        stStartQuery,
        stWaitQuery,
        stRead1,
        stPause
    } stateT;

    stateT               state;
    stateT               nextState;
    i2cSensorPkg::timerT waitTimer;
    logic                timerZero;
    logic                wrHigh;
    logic                wrLow;
    i2cSensorPkg::byteT  highByte;
    i2cSensorPkg::byteT  lowByte;

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
            state <= stIdle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState      = state;
        I2cCtrl_o      = '0;
        // address byte is the default so the data mux stays small
        I2cCtrl_o.data = DevWrite;
        Done_o         = 1'b0;
        Error_o        = 1'b0;
        wrHigh         = 1'b0;
        wrLow          = 1'b0;
        case (state)
            stIdle:
            begin
                // one-shot mode: 0x20 into config register 0x03
                if (Start_i)
                begin
                    nextState           = stWriteReq1;
                    I2cCtrl_o.fifoWrite = 1'b1;
                end
            end
            stWriteReq1:
            begin
                nextState           = stWriteReq2;
                I2cCtrl_o.data      = CfgReg;
                I2cCtrl_o.fifoWrite = 1'b1;
            end
            stWriteReq2:
            begin
                nextState           = stStartReq;
                I2cCtrl_o.data      = CfgOneShot;
                I2cCtrl_o.fifoWrite = 1'b1;
            end
            stStartReq:
            begin
                I2cCtrl_o.startProcess = 1'b1;
                nextState              = stWaitReq;
            end
            stWaitReq:
            begin
                if (I2cStat_i.error)
                begin
                    nextState = stIdle;
                    Error_o   = 1'b1;
                end
                else if (!I2cStat_i.busy)
                begin
                    nextState = stWait;
                end
            end
            stWait:
            begin
                // conversion time elapsed, set pointer to the temperature register
                if (timerZero)
                begin
                    nextState           = stWriteAddr1;
                    I2cCtrl_o.fifoWrite = 1'b1;
                end
            end
            stWriteAddr1:
            begin
                nextState           = stStartAddr;
                I2cCtrl_o.data      = TempReg;
                I2cCtrl_o.fifoWrite = 1'b1;
            end
            stStartAddr:
            begin
                I2cCtrl_o.startProcess = 1'b1;
                nextState              = stWaitAddr;
            end
            stWaitAddr:
            begin
                I2cCtrl_o.data = DevRead;
                if (I2cStat_i.error)
                begin
                    nextState = stIdle;
                    Error_o   = 1'b1;
                end
                else if (!I2cStat_i.busy)
                begin
                    nextState           = stStartQuery;
                    I2cCtrl_o.fifoWrite = 1'b1;
                end
            end
            stStartQuery:
            begin
                I2cCtrl_o.receiveSend_n = 1'b1;
                I2cCtrl_o.readCount     = ReadBytes;
                I2cCtrl_o.startProcess  = 1'b1;
                nextState               = stWaitQuery;
            end
            stWaitQuery:
            begin
                I2cCtrl_o.receiveSend_n = 1'b1;
                I2cCtrl_o.readCount     = ReadBytes;
                if (I2cStat_i.error)
                begin
                    nextState = stIdle;
                    Error_o   = 1'b1;
                end
                else if (!I2cStat_i.busy)
                begin
                    // first byte out of the FIFO is the MSB
                    nextState              = stRead1;
                    I2cCtrl_o.fifoReadNext = 1'b1;
                    wrHigh                 = 1'b1;
                end
            end
            stRead1:
            begin
                nextState              = stPause;
                I2cCtrl_o.fifoReadNext = 1'b1;
                wrLow                  = 1'b1;
            end
            stPause:
            begin
                Done_o    = 1'b1;
                nextState = stIdle;
            end
            default:
            begin
                nextState = stIdle;
            end
        endcase
    end

    // timer holds the preset until the wait state, then counts down to zero
    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
            waitTimer <= '0;
        else if (state != stWait)
            waitTimer <= WaitPreset_i;
        else if (!timerZero)
            waitTimer <= waitTimer - 1'b1;
    end

    assign timerZero = (waitTimer == '0);

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
        begin
            highByte <= '0;
            lowByte  <= '0;
        end
        else
        begin
            if (wrHigh)
                highByte <= I2cStat_i.data;
            if (wrLow)
                lowByte <= I2cStat_i.data;
        end
    end

    assign Result_o = {highByte, lowByte};
    assign Idle_o   = (state == stIdle);

    // the master takes sequencer pushes into its FIFO only while it is idle
    pushWhileIdle: assert property (@(posedge Clk_i) disable iff (rst_i)
        I2cCtrl_o.fifoWrite |-> !I2cStat_i.busy)
        else $error("fifo push while the master is busy");

endmodule

// File: tempMonitor.sv
`timescale 1ns/1ps

module tempMonitor
(
    input  logic                Clk_i,
    input  logic                rst_i,
    input  logic                Enable_i,
    input  i2cSensorPkg::timerT SamplePeriod_i,
    input  i2cSensorPkg::wordT  Threshold_i,
    input  logic                Done_i,
    input  logic                Idle_i,
    input  i2cSensorPkg::wordT  Result_i,
    output logic                Start_o,
    output logic                Interrupt_o,
    output i2cSensorPkg::wordT  Value_o
);

    i2cSensorPkg::timerT intervalCnt;
    logic                tickPending;
    i2cSensorPkg::wordT  diff;
    logic                overThreshold;

    // a pending tick waits here until the sequencer is back in idle
    assign Start_o = Enable_i && tickPending && Idle_i;

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
        begin
            intervalCnt <= '0;
            tickPending <= 1'b0;
        end
        else if (!Enable_i)
        begin
            intervalCnt <= SamplePeriod_i;
            tickPending <= 1'b0;
        end
        else if (intervalCnt == '0)
        begin
            intervalCnt <= SamplePeriod_i;
            tickPending <= 1'b1;
        end
        else
        begin
            intervalCnt <= intervalCnt - 1'b1;
            if (Start_o)
                tickPending <= 1'b0;
        end
    end

    // words compared as unsigned codes
    assign diff          = (Result_i > Value_o) ? (Result_i - Value_o) : (Value_o - Result_i);
    assign overThreshold = (diff > Threshold_i);

    always_ff @(posedge Clk_i)
    begin
        if (rst_i)
        begin
            Interrupt_o <= 1'b0;
            Value_o     <= '0;
        end
        else
        begin
            Interrupt_o <= Done_i && overThreshold;
            if (Done_i && overThreshold)
                Value_o <= Result_i;
        end
    end

endmodule

// File: sensorTop.sv
`timescale 1ns/1ps

module sensorTop
#(
    parameter int ClkDiv    = 4,
    parameter int FifoDepth = 4
)
(
    input  logic                Clk_i,
    input  logic                rst_i,
    input  logic                Enable_i,
    input  i2cSensorPkg::timerT SamplePeriod_i,
    input  i2cSensorPkg::timerT WaitPreset_i,
    input  i2cSensorPkg::wordT  Threshold_i,
    input  logic                scl_i,
    input  logic                sda_i,
    output logic                sclDriveLow_o,
    output logic                sdaDriveLow_o,
    output logic                Interrupt_o,
    output logic                Error_o,
    output logic                Done_o,
    output i2cSensorPkg::wordT  Value_o
);

    logic                  start;
    logic                  seqIdle;
    i2cSensorPkg::wordT    result;
    i2cSensorPkg::i2cCtrlT i2cCtrl;
    i2cSensorPkg::i2cStatT i2cStat;

    tempMonitor tempMonitorI
    (
        .Clk_i          (Clk_i),
        .rst_i          (rst_i),
        .Enable_i       (Enable_i),
        .SamplePeriod_i (SamplePeriod_i),
        .Threshold_i    (Threshold_i),
        .Done_i         (Done_o),
        .Idle_i         (seqIdle),
        .Result_i       (result),
        .Start_o        (start),
        .Interrupt_o    (Interrupt_o),
        .Value_o        (Value_o)
    );

    adt7410Fsm adt7410FsmI
    (
        .Clk_i        (Clk_i),
        .rst_i        (rst_i),
        .Start_i      (start),
        .WaitPreset_i (WaitPreset_i),
        .I2cStat_i    (i2cStat),
        .I2cCtrl_o    (i2cCtrl),
        .Done_o       (Done_o),
        .Error_o      (Error_o),
        .Idle_o       (seqIdle),
        .Result_o     (result)
    );

    i2cMaster
    #(
        .ClkDiv    (ClkDiv),
        .FifoDepth (FifoDepth)
    )
    i2cMasterI
    (
        .Clk_i         (Clk_i),
        .rst_i         (rst_i),
        .I2cCtrl_i     (i2cCtrl),
        .I2cStat_o     (i2cStat),
        .scl_i         (scl_i),
        .sda_i         (sda_i),
        .sclDriveLow_o (sclDriveLow_o),
        .sdaDriveLow_o (sdaDriveLow_o)
    );

endmodule

// File: tbTempSensorModel.sv
`timescale 1ns/1ps

// behavioral I2C slave answering like an ADT7410 at address 0x48
module tbTempSensorModel
(
    input  logic        rst_i,
    input  logic        scl_i,
    input  logic        sda_i,
    input  logic [15:0] tempWord_i,
    input  logic        forceNack_i,
    output logic        sdaDriveLow_o,
    output logic        badByte_o
);

    logic       prevScl;
    logic       prevSda;
    logic       inFrame;
    logic       readDir;
    logic       addrAcked;
    logic       ackThis;
    logic       masterAck;
    int         bitIdx;
    int         byteIdx;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [7:0] pointerReg;
    logic [7:0] configReg;
    // every byte the master has written, addresses included
    logic [7:0] logged [512];
    int         logCount;

    initial
    begin
        prevScl       = 1'b1;
        prevSda       = 1'b1;
        inFrame       = 1'b0;
        readDir       = 1'b0;
        addrAcked     = 1'b0;
        ackThis       = 1'b0;
        masterAck     = 1'b0;
        bitIdx        = 0;
        byteIdx       = 0;
        shiftIn       = 8'h00;
        txByte        = 8'h00;
        pointerReg    = 8'h00;
        configReg     = 8'h00;
        logCount      = 0;
        sdaDriveLow_o = 1'b0;
        badByte_o     = 1'b0;
    end

    // pointer 0x00 gives the temperature MSB first, anything else the config register
    function automatic logic [7:0] registerByte(input int idx);
        if (pointerReg == 8'h00)
            return (idx == 0) ? tempWord_i[15:8] : tempWord_i[7:0];
        return configReg;
    endfunction

    task reportBad(input string what);
        $display("sensor model: unexpected %s byte %h at %0t ns", what, shiftIn, $time);
        badByte_o = 1'b1;
    endtask

    task takeByte;
        if (logCount < 512)
            logged[logCount] = shiftIn;
        logCount = logCount + 1;
        ackThis  = 1'b1;
        if (byteIdx == 0)
        begin
            readDir   = shiftIn[0];
            ackThis   = !forceNack_i;
            addrAcked = ackThis;
            if (shiftIn[7:1] != 7'h48)
                reportBad("address");
        end
        else if (byteIdx == 1)
        begin
            pointerReg = shiftIn;
            if (shiftIn != 8'h00 && shiftIn != 8'h03)
                reportBad("pointer");
        end
        else if (byteIdx == 2 && pointerReg == 8'h03)
        begin
            configReg = shiftIn;
            if (shiftIn != 8'h20)
                reportBad("configuration");
        end
        else
            reportBad("surplus");
    endtask

    task sampleBit;
        if (bitIdx < 8)
        begin
            shiftIn = {shiftIn[6:0], sda_i};
            bitIdx  = bitIdx + 1;
            if (bitIdx == 8 && (byteIdx == 0 || !readDir))
                takeByte();
        end
        else
        begin
            // ninth clock, master acknowledge on read data
            if (readDir && byteIdx > 0)
                masterAck = !sda_i;
            bitIdx  = 0;
            byteIdx = byteIdx + 1;
        end
    endtask

    task driveBit;
        if (bitIdx == 8)
            sdaDriveLow_o = (byteIdx == 0 || !readDir) ? ackThis : 1'b0;
        else if (bitIdx == 0)
        begin
            // ninth clock over, start the next read byte or let go
            if (readDir && addrAcked && byteIdx > 0 && (byteIdx == 1 || masterAck))
            begin
                txByte        = registerByte(byteIdx - 1);
                sdaDriveLow_o = !txByte[7];
            end
            else
                sdaDriveLow_o = 1'b0;
        end
        else if (readDir && addrAcked && byteIdx > 0)
            sdaDriveLow_o = !txByte[7 - bitIdx];
    endtask

    always @(scl_i or sda_i or rst_i)
    begin
        if (rst_i)
        begin
            inFrame       = 1'b0;
            sdaDriveLow_o = 1'b0;
        end
        else if (scl_i === 1'b1 && prevScl === 1'b1 && sda_i !== prevSda)
        begin
            // SDA falling under a high SCL is a start, rising is a stop
            inFrame       = (sda_i === 1'b0);
            readDir       = 1'b0;
            addrAcked     = 1'b0;
            masterAck     = 1'b0;
            bitIdx        = 0;
            byteIdx       = 0;
            sdaDriveLow_o = 1'b0;
        end
        else if (inFrame && scl_i === 1'b1 && prevScl === 1'b0)
            sampleBit();
        else if (inFrame && scl_i === 1'b0 && prevScl === 1'b1)
            driveBit();
        prevScl = scl_i;
        prevSda = sda_i;
    end

endmodule

// File: tbSensorTop.sv
`timescale 1ns/1ps

module tbSensorTop;

    localparam int ClkDiv          = 2;
    localparam int FifoDepth       = 4;
    localparam int NumSamples      = 40;
    localparam int MaxPeriod       = 7;
    localparam int MaxWait         = 15;
    // config, pointer and read transfers in bit times, start and stop included
    localparam int BitsPerSample   = 80;
    localparam int CyclesPerSample = BitsPerSample * 4 * ClkDiv + MaxWait + MaxPeriod + 16;
    localparam int TimeoutCycles   = NumSamples * CyclesPerSample * 2;

    logic        clk;
    logic        rst;
    logic        enable;
    logic [31:0] samplePeriod;
    logic [31:0] waitPreset;
    logic [15:0] threshold;
    logic        sclLow;
    logic        sdaLow;
    logic        modelSdaLow;
    logic        scl;
    logic        sda;
    logic        interrupt;
    logic        error;
    logic        done;
    logic [15:0] value;
    logic [15:0] tempWord;
    logic        forceNack;
    logic        badByte;

    integer      seed;
    int          cycleCount;
    int          sample;
    int          k;
    int          logStart;
    int          interruptCount;
    logic        nackThis;
    logic        lastNack;
    logic        expInterrupt;
    logic [15:0] expValue;

    // open-drain lines with pull-ups
    assign scl = !sclLow;
    assign sda = !(sdaLow || modelSdaLow);

    sensorTop
    #(
        .ClkDiv    (ClkDiv),
        .FifoDepth (FifoDepth)
    )
    dut_i
    (
        .Clk_i          (clk),
        .rst_i          (rst),
        .Enable_i       (enable),
        .SamplePeriod_i (samplePeriod),
        .WaitPreset_i   (waitPreset),
        .Threshold_i    (threshold),
        .scl_i          (scl),
        .sda_i          (sda),
        .sclDriveLow_o  (sclLow),
        .sdaDriveLow_o  (sdaLow),
        .Interrupt_o    (interrupt),
        .Error_o        (error),
        .Done_o         (done),
        .Value_o        (value)
    );

    tbTempSensorModel sensorModel
    (
        .rst_i         (rst),
        .scl_i         (scl),
        .sda_i         (sda),
        .tempWord_i    (tempWord),
        .forceNack_i   (forceNack),
        .sdaDriveLow_o (modelSdaLow),
        .badByte_o     (badByte)
    );

    always
    begin : clkGen
        #2 clk = ~clk;
    end

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic int absDiff(input logic [15:0] a, input logic [15:0] b);
        int d;
        d = int'(a) - int'(b);
        return (d < 0) ? -d : d;
    endfunction

    // config write, pointer write, then the read address
    function automatic logic [7:0] expectedBusByte(input int idx);
        case (idx)
            0:       return 8'h90;
            1:       return 8'h03;
            2:       return 8'h20;
            3:       return 8'h90;
            4:       return 8'h00;
            default: return 8'h91;
        endcase
    endfunction

    // ends on the falling edge where Done or Error is seen
    task waitForSampleEnd;
        @(negedge clk);
        while (!done && !error)
        begin
            checkValue(interrupt, 0, "interrupt while a sample runs");
            @(negedge clk);
        end
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles)
            stopWithError("timeout: a sample did not finish within the cycle limit");
    end

    always @(posedge badByte)
    begin
        stopWithError("the sensor model saw an unexpected byte on the bus");
    end

    initial
    begin
        clk            = 1'b0;
        rst            = 1'b1;
        enable         = 1'b0;
        samplePeriod   = '0;
        waitPreset     = '0;
        threshold      = '0;
        tempWord       = '0;
        forceNack      = 1'b0;
        seed           = 32'hfa235d61;
        cycleCount     = 0;
        interruptCount = 0;
        lastNack       = 1'b0;
        expValue       = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        checkValue(done, 0, "Done_o after reset");
        checkValue(error, 0, "Error_o after reset");
        checkValue(interrupt, 0, "Interrupt_o after reset");
        checkValue(sclLow, 0, "SCL drive after reset");
        checkValue(sdaLow, 0, "SDA drive after reset");
        checkValue(value, 0, "Value_o after reset");
        rst = 1'b0;

        for (sample = 0; sample < NumSamples; sample++)
        begin
            nackThis = !lastNack && ((sample == 2) || (($random(seed) & 7) == 0));
            if (($random(seed) & 3) == 0)
                tempWord = $random(seed);
            else
                tempWord = expValue + 16'($random(seed) % 512);
            threshold    = $random(seed) & 16'h01ff;
            samplePeriod = $random(seed) & MaxPeriod;
            waitPreset   = $random(seed) & MaxWait;
            forceNack    = nackThis;
            logStart     = sensorModel.logCount;
            enable       = 1'b1;

            waitForSampleEnd();
            enable = 1'b0;

            if (nackThis)
            begin
                checkValue(error, 1, "Error_o on a refused address");
                checkValue(done, 0, "Done_o on a refused address");
                checkValue(sensorModel.logCount - logStart, 1, "bytes before the NACK");
                checkValue(sensorModel.logged[logStart], 8'h90, "refused address byte");
                expInterrupt = 1'b0;
            end
            else
            begin
                checkValue(done, 1, "Done_o at the end of a sample");
                checkValue(error, 0, "Error_o on a good sample");
                checkValue(dut_i.result, tempWord, "temperature word read");
                checkValue(sensorModel.logCount - logStart, 6, "bytes written per sample");
                for (k = 0; k < 6; k++)
                    checkValue(sensorModel.logged[logStart + k], expectedBusByte(k),
                               "byte written on the bus");
                expInterrupt = (absDiff(tempWord, expValue) > int'(threshold));
            end

            @(negedge clk);
            checkValue(interrupt, expInterrupt, "Interrupt_o after the sample");
            if (expInterrupt)
            begin
                expValue       = tempWord;
                interruptCount = interruptCount + 1;
            end
            checkValue(value, expValue, "Value_o after the sample");
            forceNack = 1'b0;
            lastNack  = nackThis;
        end

        $display("%0d samples, %0d interrupts", NumSamples, interruptCount);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
i2cSensorPkg.sv
i2cByteFifo.sv
i2cMaster.sv
adt7410Fsm.sv
tempMonitor.sv
sensorTop.sv
tbTempSensorModel.sv
tbSensorTop.sv
